//--- src/axis_switch_pkg.sv
package axis_switch_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Stream widths
    ///////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;
    localparam int strb_width = 4;
    localparam int user_width = 2;
    localparam int tid_width = 2;

    // Upstream arbitration
    localparam int num_sources = 3;

    // Downstream ingress FIFO
    localparam int fifo_depth = 16;
    localparam int fifo_addr_width = 4;
    localparam int fifo_threshold = 6;

    ///////////////////////////////////////////////////////////////////////
    // Beat formats
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [strb_width-1:0] keep;
        logic                  last;
        logic [user_width-1:0] user;
    } stream_beat_t;

    // Format on the serdes link and in each FIFO entry
    typedef struct packed {
        stream_beat_t         beat;
        logic [tid_width-1:0] tid;
    } serdes_beat_t;

    typedef enum logic [tid_width-1:0] {
        src_up = 2'd0,
        src_aa = 2'd1,
        src_la = 2'd2
    } source_e;

    typedef enum logic {
        arb_idle,
        arb_locked
    } arb_state_e;

    // Bit k grants source id k
    typedef logic [num_sources-1:0] grant_t;

endpackage

//--- src/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter (
    input  logic                    axis_clk,
    input  logic                    axi_reset_n,
    input  axis_switch_pkg::grant_t req,
    input  logic                    accept_last,
    output axis_switch_pkg::grant_t grant
);

    axis_switch_pkg::arb_state_e state;

    // Source id with the highest priority in the next arbitration
    logic [axis_switch_pkg::tid_width-1:0] base_ptr;

    axis_switch_pkg::grant_t               pick;
    logic [axis_switch_pkg::tid_width-1:0] pick_id;
    logic [axis_switch_pkg::tid_width-1:0] next_ptr;

    ///////////////////////////////////////////////////////////////////////
    // Rotated priority pick
    ///////////////////////////////////////////////////////////////////////

    // Walk from the farthest offset back to the pointer,
    // so the requester closest to base_ptr is the one left standing
    always_comb begin
        int slot;
        pick = '0;
        pick_id = base_ptr;
        for (int i = axis_switch_pkg::num_sources - 1; i >= 0; i--) begin
            slot = int'(base_ptr) + i;
            if (slot >= axis_switch_pkg::num_sources) begin
                slot = slot - axis_switch_pkg::num_sources;
            end
            if (req[slot]) begin
                pick = '0;
                pick[slot] = 1'b1;
                pick_id = slot[axis_switch_pkg::tid_width-1:0];
            end
        end
    end

    // Pointer moves just past the winner
    assign next_ptr = (pick_id == axis_switch_pkg::num_sources - 1) ? '0 : pick_id + 1'b1;

    ///////////////////////////////////////////////////////////////////////
    // Grant and frame lock
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state <= axis_switch_pkg::arb_idle;
            base_ptr <= '0;
            grant <= '0;
        end else begin
            case (state)
                axis_switch_pkg::arb_idle: begin
                    if (|req) begin
                        grant <= pick;
                        base_ptr <= next_ptr;
                        state <= axis_switch_pkg::arb_locked;
                    end
                end
                axis_switch_pkg::arb_locked: begin
                    // Frame done once its tlast beat has been taken
                    if (accept_last) begin
                        grant <= '0;
                        state <= axis_switch_pkg::arb_idle;
                    end
                end
                default: begin
                    grant <= '0;
                    state <= axis_switch_pkg::arb_idle;
                end
            endcase
        end
    end

endmodule

//--- src/upstream_mux.sv
`timescale 1ns/1ns

module upstream_mux (
    input  logic                          axis_clk,
    input  logic                          axi_reset_n,
    input  axis_switch_pkg::grant_t       grant,
    input  axis_switch_pkg::stream_beat_t up_as,
    input  axis_switch_pkg::stream_beat_t aa_as,
    input  axis_switch_pkg::stream_beat_t la_as,
    input  logic                          up_as_tvalid,
    input  logic                          aa_as_tvalid,
    input  logic                          la_as_tvalid,
    input  logic                          is_as_tready,
    output logic                          as_up_tready,
    output logic                          as_aa_tready,
    output logic                          as_la_tready,
    output axis_switch_pkg::serdes_beat_t as_is,
    output logic                          as_is_tvalid,
    output logic                          accept_last
);

    logic                          out_busy;
    logic                          take;
    axis_switch_pkg::stream_beat_t sel_beat;
    logic                          sel_valid;
    axis_switch_pkg::source_e      sel_id;

    // Output register holds a beat the serdes has not taken yet
    assign out_busy = as_is_tvalid && !is_as_tready;

    ///////////////////////////////////////////////////////////////////////
    // Source select
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_beat = up_as;
        sel_valid = 1'b0;
        sel_id = axis_switch_pkg::src_up;
        if (grant[axis_switch_pkg::src_up]) begin
            sel_valid = up_as_tvalid;
        end else if (grant[axis_switch_pkg::src_aa]) begin
            sel_beat = aa_as;
            sel_valid = aa_as_tvalid;
            sel_id = axis_switch_pkg::src_aa;
        end else if (grant[axis_switch_pkg::src_la]) begin
            sel_beat = la_as;
            sel_valid = la_as_tvalid;
            sel_id = axis_switch_pkg::src_la;
        end
    end

    // Only the granted source ever sees ready
    assign as_up_tready = grant[axis_switch_pkg::src_up] && !out_busy;
    assign as_aa_tready = grant[axis_switch_pkg::src_aa] && !out_busy;
    assign as_la_tready = grant[axis_switch_pkg::src_la] && !out_busy;

    assign take = sel_valid && !out_busy;
    assign accept_last = take && sel_beat.last;

    ///////////////////////////////////////////////////////////////////////
    // Serdes output stage
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            as_is_tvalid <= 1'b0;
        end else if (take) begin
            as_is_tvalid <= 1'b1;
        end else if (is_as_tready) begin
            as_is_tvalid <= 1'b0;
        end
    end

    // Stamp the source id on tid
    always_ff @(posedge axis_clk) begin
        if (take) begin
            as_is.beat <= sel_beat;
            as_is.tid <= sel_id;
        end
    end

endmodule

//--- src/downstream_fifo.sv
`timescale 1ns/1ns

module downstream_fifo (
    input  logic                          axis_clk,
    input  logic                          axi_reset_n,
    input  axis_switch_pkg::serdes_beat_t is_as,
    input  logic                          is_as_tvalid,
    output logic                          as_is_tready,
    output axis_switch_pkg::stream_beat_t as_up,
    output axis_switch_pkg::stream_beat_t as_aa,
    output logic                          as_up_tvalid,
    output logic                          as_aa_tvalid,
    input  logic                          up_as_tready,
    input  logic                          aa_as_tready
);

    axis_switch_pkg::serdes_beat_t mem [axis_switch_pkg::fifo_depth];

    // Pointers carry one extra wrap bit
    logic [axis_switch_pkg::fifo_addr_width:0] wr_ptr;
    logic [axis_switch_pkg::fifo_addr_width:0] rd_ptr;
    logic [axis_switch_pkg::fifo_addr_width:0] count;

    logic                          full;
    logic                          empty;
    logic                          push;
    logic                          pop;
    axis_switch_pkg::serdes_beat_t head;
    axis_switch_pkg::source_e      head_tid;

    ///////////////////////////////////////////////////////////////////////
    // Occupancy and link back-pressure
    ///////////////////////////////////////////////////////////////////////

    assign count = wr_ptr - rd_ptr;
    assign full = (count == axis_switch_pkg::fifo_depth);
    assign empty = (count == '0);

    // Serdes needs a few cycles to react, hence the margin below full
    assign as_is_tready = !(count > axis_switch_pkg::fifo_threshold);

    assign push = is_as_tvalid && !full;

    always_ff @(posedge axis_clk) begin
        if (push) begin
            mem[wr_ptr[axis_switch_pkg::fifo_addr_width-1:0]] <= is_as;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Head routing by tid
    ///////////////////////////////////////////////////////////////////////

    assign head = mem[rd_ptr[axis_switch_pkg::fifo_addr_width-1:0]];
    assign head_tid = axis_switch_pkg::source_e'(head.tid);

    assign as_up = head.beat;
    assign as_aa = head.beat;

    assign as_up_tvalid = !empty && (head_tid == axis_switch_pkg::src_up);
    assign as_aa_tvalid = !empty && (head_tid == axis_switch_pkg::src_aa);

    always_comb begin
        pop = 1'b0;
        if (!empty) begin
            case (head_tid)
                axis_switch_pkg::src_up: pop = up_as_tready;
                axis_switch_pkg::src_aa: pop = aa_as_tready;
                // No sink for this id, drop it
                default: pop = 1'b1;
            endcase
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Pointers
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- src/axis_switch.sv
`timescale 1ns/1ns

module axis_switch (
    input  logic                          axis_clk,
    input  logic                          axi_reset_n,

    // Upstream sources
    input  axis_switch_pkg::stream_beat_t up_as,
    input  logic                          up_as_tvalid,
    output logic                          as_up_tready,
    input  axis_switch_pkg::stream_beat_t aa_as,
    input  logic                          aa_as_tvalid,
    output logic                          as_aa_tready,
    input  axis_switch_pkg::stream_beat_t la_as,
    input  logic                          la_as_tvalid,
    output logic                          as_la_tready,

    // To io serdes
    output axis_switch_pkg::serdes_beat_t as_is,
    output logic                          as_is_tvalid,
    input  logic                          is_as_tready,

    // From io serdes
    input  axis_switch_pkg::serdes_beat_t is_as,
    input  logic                          is_as_tvalid,
    output logic                          as_is_tready,

    // Downstream sinks
    output axis_switch_pkg::stream_beat_t as_up,
    output logic                          as_up_tvalid,
    input  logic                          up_as_tready,
    output axis_switch_pkg::stream_beat_t as_aa,
    output logic                          as_aa_tvalid,
    input  logic                          aa_as_tready
);

    axis_switch_pkg::grant_t req;
    axis_switch_pkg::grant_t grant;
    logic                    accept_last;

    // Bit position matches the source id
    assign req = {la_as_tvalid, aa_as_tvalid, up_as_tvalid};

    ///////////////////////////////////////////////////////////////////////
    // Upstream path
    ///////////////////////////////////////////////////////////////////////

    rr_arbiter u_arbiter (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .req         (req),
        .accept_last (accept_last),
        .grant       (grant)
    );

    upstream_mux u_mux (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .grant        (grant),
        .up_as        (up_as),
        .aa_as        (aa_as),
        .la_as        (la_as),
        .up_as_tvalid (up_as_tvalid),
        .aa_as_tvalid (aa_as_tvalid),
        .la_as_tvalid (la_as_tvalid),
        .is_as_tready (is_as_tready),
        .as_up_tready (as_up_tready),
        .as_aa_tready (as_aa_tready),
        .as_la_tready (as_la_tready),
        .as_is        (as_is),
        .as_is_tvalid (as_is_tvalid),
        .accept_last  (accept_last)
    );

    ///////////////////////////////////////////////////////////////////////
    // Downstream path
    ///////////////////////////////////////////////////////////////////////

    downstream_fifo u_fifo (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .is_as        (is_as),
        .is_as_tvalid (is_as_tvalid),
        .as_is_tready (as_is_tready),
        .as_up        (as_up),
        .as_aa        (as_aa),
        .as_up_tvalid (as_up_tvalid),
        .as_aa_tvalid (as_aa_tvalid),
        .up_as_tready (up_as_tready),
        .aa_as_tready (aa_as_tready)
    );

endmodule

//--- sim/axis_switch_checks.svh
`ifndef axis_switch_checks_svh
`define axis_switch_checks_svh

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_serdes_beat(
    input string                         what,
    input axis_switch_pkg::serdes_beat_t expected,
    input axis_switch_pkg::serdes_beat_t actual
);
    if (actual !== expected) begin
        $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1, "serdes beat mismatch");
    end
endtask

task automatic check_stream_beat(
    input string                         what,
    input axis_switch_pkg::stream_beat_t expected,
    input axis_switch_pkg::stream_beat_t actual
);
    if (actual !== expected) begin
        $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1, "stream beat mismatch");
    end
endtask

task automatic check_level(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("FAIL %s: %s expected %b actual %b", test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1, "level mismatch");
    end
endtask

//////////////////////////////////////////////////////////////////////
// Bounded waits, each returns at the falling edge where it succeeded
//////////////////////////////////////////////////////////////////////

task automatic report_timeout(input string what);
    $display("Timeout in %s: no %s after %0d cycles", test_name, what, wait_limit);
    $display("Test failed");
    $fatal(1, "wait timed out");
endtask

function automatic logic source_ready(input axis_switch_pkg::source_e src);
    case (src)
        axis_switch_pkg::src_up: return as_up_tready;
        axis_switch_pkg::src_aa: return as_aa_tready;
        default: return as_la_tready;
    endcase
endfunction

function automatic logic sink_valid(input axis_switch_pkg::source_e dst);
    if (dst == axis_switch_pkg::src_up) begin
        return as_up_tvalid;
    end
    return as_aa_tvalid;
endfunction

task automatic wait_source_ready(input axis_switch_pkg::source_e src);
    int n;
    n = 0;
    @(negedge axis_clk);
    while (!source_ready(src) && n < wait_limit) begin
        @(negedge axis_clk);
        n++;
    end
    if (!source_ready(src)) begin
        report_timeout($sformatf("ready for source %0d", src));
    end
endtask

task automatic wait_serdes_valid();
    int n;
    n = 0;
    @(negedge axis_clk);
    while (!as_is_tvalid && n < wait_limit) begin
        @(negedge axis_clk);
        n++;
    end
    if (!as_is_tvalid) begin
        report_timeout("valid beat on the serdes output");
    end
endtask

task automatic wait_link_ready();
    int n;
    n = 0;
    @(negedge axis_clk);
    while (!as_is_tready && n < wait_limit) begin
        @(negedge axis_clk);
        n++;
    end
    if (!as_is_tready) begin
        report_timeout("ready level towards the serdes");
    end
endtask

task automatic wait_sink_valid(input axis_switch_pkg::source_e dst);
    int n;
    n = 0;
    @(negedge axis_clk);
    while (!sink_valid(dst) && n < wait_limit) begin
        @(negedge axis_clk);
        n++;
    end
    if (!sink_valid(dst)) begin
        report_timeout($sformatf("valid beat at sink %0d", dst));
    end
endtask

`endif

//--- sim/axis_switch_tb.sv
`timescale 1ns/1ns

module axis_switch_tb;

    localparam int wait_limit = 200;

    logic                          axis_clk;
    logic                          axi_reset_n;
    axis_switch_pkg::stream_beat_t up_as;
    axis_switch_pkg::stream_beat_t aa_as;
    axis_switch_pkg::stream_beat_t la_as;
    logic                          up_as_tvalid;
    logic                          aa_as_tvalid;
    logic                          la_as_tvalid;
    logic                          as_up_tready;
    logic                          as_aa_tready;
    logic                          as_la_tready;
    axis_switch_pkg::serdes_beat_t as_is;
    logic                          as_is_tvalid;
    logic                          is_as_tready;
    axis_switch_pkg::serdes_beat_t is_as;
    logic                          is_as_tvalid;
    logic                          as_is_tready;
    axis_switch_pkg::stream_beat_t as_up;
    axis_switch_pkg::stream_beat_t as_aa;
    logic                          as_up_tvalid;
    logic                          as_aa_tvalid;
    logic                          up_as_tready;
    logic                          aa_as_tready;

    string test_name;

    // Per-source beats and the expected order at each output
    axis_switch_pkg::stream_beat_t frame_beats [3][4];
    axis_switch_pkg::serdes_beat_t link_expect [$];
    axis_switch_pkg::stream_beat_t up_expect [$];
    axis_switch_pkg::stream_beat_t aa_expect [$];

    axis_switch u_dut (.*);

    `include "axis_switch_checks.svh"

    initial begin
        axis_clk = 1'b0;
        forever begin
            #20 axis_clk = ~axis_clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////////////////////////

    // Rising edge plus a small hold margin
    task automatic advance_cycle();
        @(posedge axis_clk);
        #2;
    endtask

    task automatic apply_reset();
        axi_reset_n = 1'b0;
        repeat (5) @(posedge axis_clk);
        #2;
        axi_reset_n = 1'b1;
    endtask

    function automatic axis_switch_pkg::stream_beat_t make_beat(
        input logic [axis_switch_pkg::data_width-1:0] word,
        input logic                                   last
    );
        axis_switch_pkg::stream_beat_t b;
        b.data = word;
        b.strb = word[3:0];
        b.keep = '1;
        b.last = last;
        b.user = word[5:4];
        return b;
    endfunction

    function automatic axis_switch_pkg::serdes_beat_t tag_beat(
        input axis_switch_pkg::stream_beat_t        b,
        input logic [axis_switch_pkg::tid_width-1:0] tid
    );
        axis_switch_pkg::serdes_beat_t t;
        t.beat = b;
        t.tid = tid;
        return t;
    endfunction

    task automatic present_beat(
        input axis_switch_pkg::source_e      src,
        input axis_switch_pkg::stream_beat_t b,
        input logic                          valid
    );
        case (src)
            axis_switch_pkg::src_up: begin
                up_as = b;
                up_as_tvalid = valid;
            end
            axis_switch_pkg::src_aa: begin
                aa_as = b;
                aa_as_tvalid = valid;
            end
            default: begin
                la_as = b;
                la_as_tvalid = valid;
            end
        endcase
    endtask

    task automatic send_beat(
        input axis_switch_pkg::source_e      src,
        input axis_switch_pkg::stream_beat_t b
    );
        present_beat(src, b, 1'b1);
        wait_source_ready(src);
        advance_cycle();
        present_beat(src, b, 1'b0);
    endtask

    task automatic drive_beats(input axis_switch_pkg::source_e src, input int n);
        for (int i = 0; i < n; i++) begin
            send_beat(src, frame_beats[int'(src)][i]);
        end
    endtask

    // Serdes raises valid only after it has seen the ready level high
    task automatic send_link_beat(input axis_switch_pkg::serdes_beat_t b);
        wait_link_ready();
        advance_cycle();
        is_as = b;
        is_as_tvalid = 1'b1;
        advance_cycle();
        is_as_tvalid = 1'b0;
    endtask

    task automatic collect_serdes(input int n);
        axis_switch_pkg::serdes_beat_t got;
        for (int i = 0; i < n; i++) begin
            wait_serdes_valid();
            got = as_is;
            check_serdes_beat($sformatf("serdes beat %0d", i), link_expect.pop_front(), got);
            advance_cycle();
        end
    endtask

    task automatic collect_sink(input axis_switch_pkg::source_e dst, input int n);
        axis_switch_pkg::stream_beat_t got;
        for (int i = 0; i < n; i++) begin
            wait_sink_valid(dst);
            if (dst == axis_switch_pkg::src_up) begin
                got = as_up;
                check_stream_beat($sformatf("up beat %0d", i), up_expect.pop_front(), got);
            end else begin
                got = as_aa;
                check_stream_beat($sformatf("aa beat %0d", i), aa_expect.pop_front(), got);
            end
            advance_cycle();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_levels();
        test_name = "check_reset_levels";
        @(negedge axis_clk);
        check_level("as_is_tvalid", 1'b0, as_is_tvalid);
        check_level("as_up_tready", 1'b0, as_up_tready);
        check_level("as_aa_tready", 1'b0, as_aa_tready);
        check_level("as_la_tready", 1'b0, as_la_tready);
        check_level("as_up_tvalid", 1'b0, as_up_tvalid);
        check_level("as_aa_tvalid", 1'b0, as_aa_tvalid);
        check_level("as_is_tready", 1'b1, as_is_tready);
        advance_cycle();
    endtask

    task automatic test_single_source();
        axis_switch_pkg::source_e      src;
        axis_switch_pkg::stream_beat_t b;
        test_name = "test_single_source";
        for (int s = 0; s < 3; s++) begin
            src = axis_switch_pkg::source_e'(s);
            b = make_beat($urandom, 1'b1);
            send_beat(src, b);
            // Registered stage puts the beat out one cycle after transfer
            @(negedge axis_clk);
            check_level("as_is_tvalid", 1'b1, as_is_tvalid);
            check_serdes_beat("serdes beat", tag_beat(b, src), as_is);
            advance_cycle();
        end
    endtask

    task automatic test_round_robin();
        test_name = "test_round_robin";
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 4; i++) begin
                frame_beats[s][i] = make_beat($urandom, i % 2 == 1);
            end
        end
        // up, aa, la, then the second up frame
        for (int i = 0; i < 2; i++) begin
            link_expect.push_back(tag_beat(frame_beats[0][i], axis_switch_pkg::src_up));
        end
        for (int i = 0; i < 2; i++) begin
            link_expect.push_back(tag_beat(frame_beats[1][i], axis_switch_pkg::src_aa));
        end
        for (int i = 0; i < 2; i++) begin
            link_expect.push_back(tag_beat(frame_beats[2][i], axis_switch_pkg::src_la));
        end
        for (int i = 2; i < 4; i++) begin
            link_expect.push_back(tag_beat(frame_beats[0][i], axis_switch_pkg::src_up));
        end
        fork
            drive_beats(axis_switch_pkg::src_up, 4);
            drive_beats(axis_switch_pkg::src_aa, 2);
            drive_beats(axis_switch_pkg::src_la, 2);
            collect_serdes(8);
        join
    endtask

    task automatic test_serdes_backpressure();
        axis_switch_pkg::serdes_beat_t held;
        test_name = "test_serdes_backpressure";
        for (int i = 0; i < 4; i++) begin
            frame_beats[2][i] = make_beat($urandom, i == 3);
            link_expect.push_back(tag_beat(frame_beats[2][i], axis_switch_pkg::src_la));
        end
        fork
            drive_beats(axis_switch_pkg::src_la, 4);
            begin
                collect_serdes(1);
                is_as_tready = 1'b0;
                wait_serdes_valid();
                // Second beat of the frame sits in the output register
                held = link_expect[0];
                repeat (5) begin
                    advance_cycle();
                    @(negedge axis_clk);
                    check_level("as_is_tvalid held", 1'b1, as_is_tvalid);
                    check_level("as_la_tready stalled", 1'b0, as_la_tready);
                    check_serdes_beat("held beat", held, as_is);
                end
                advance_cycle();
                is_as_tready = 1'b1;
                collect_serdes(3);
            end
        join
    endtask

    task automatic test_demux_routing();
        axis_switch_pkg::serdes_beat_t beats [8];
        test_name = "test_demux_routing";
        for (int i = 0; i < 8; i++) begin
            beats[i] = tag_beat(make_beat($urandom, 1'b1), 2'(i % 4));
            if (i % 4 == 0) begin
                up_expect.push_back(beats[i].beat);
            end else if (i % 4 == 1) begin
                aa_expect.push_back(beats[i].beat);
            end
        end
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    send_link_beat(beats[i]);
                end
            end
            collect_sink(axis_switch_pkg::src_up, 2);
            collect_sink(axis_switch_pkg::src_aa, 2);
        join
        repeat (3) advance_cycle();
        @(negedge axis_clk);
        check_level("as_up_tvalid after drain", 1'b0, as_up_tvalid);
        check_level("as_aa_tvalid after drain", 1'b0, as_aa_tvalid);
        advance_cycle();
    endtask

    task automatic test_fifo_threshold();
        axis_switch_pkg::stream_beat_t b;
        test_name = "test_fifo_threshold";
        up_as_tready = 1'b0;
        for (int i = 0; i < 7; i++) begin
            b = make_beat($urandom, 1'b0);
            up_expect.push_back(b);
            send_link_beat(tag_beat(b, axis_switch_pkg::src_up));
        end
        @(negedge axis_clk);
        check_level("as_is_tready with 7 stored", 1'b0, as_is_tready);
        advance_cycle();
        up_as_tready = 1'b1;
        collect_sink(axis_switch_pkg::src_up, 7);
        @(negedge axis_clk);
        check_level("as_is_tready after drain", 1'b1, as_is_tready);
        check_level("as_up_tvalid after drain", 1'b0, as_up_tvalid);
        advance_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h1bbe));
        test_name = "init";
        up_as = '0;
        aa_as = '0;
        la_as = '0;
        up_as_tvalid = 1'b0;
        aa_as_tvalid = 1'b0;
        la_as_tvalid = 1'b0;
        is_as_tready = 1'b1;
        is_as = '0;
        is_as_tvalid = 1'b0;
        up_as_tready = 1'b1;
        aa_as_tready = 1'b1;
        apply_reset();
        check_reset_levels();
        test_single_source();
        // Pointer back to up for the rotation order
        apply_reset();
        test_round_robin();
        test_serdes_backpressure();
        test_demux_routing();
        test_fifo_threshold();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- files.f
+incdir+sim
src/axis_switch_pkg.sv
src/rr_arbiter.sv
src/upstream_mux.sv
src/downstream_fifo.sv
src/axis_switch.sv
sim/axis_switch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the axis_switch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module axis_switch_tb -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vaxis_switch_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
